/* hdl/apu_consts.svh */
// widths, register map, interrupt vectors and timer taps of the sound block
`ifndef APU_CONSTS_SVH
`define APU_CONSTS_SVH

// widths
`define APU_ADDR_W 2
`define APU_DATA_W 8
`define APU_TC_W   9
`define APU_PNC1_W 7
`define APU_PNC2_W 3
`define APU_NUC_W  3
`define APU_VEC_W  12

// host register map
`define APU_REG_MODE 2'd0
`define APU_REG_N    2'd1
`define APU_REG_DA   2'd2
`define APU_REG_SIGN 2'd3

// vector bases, tone adds a range offset
`define APU_VEC_TONE 12'h020
`define APU_VEC_NS   12'h048
`define APU_VEC_TIME 12'h080
`define APU_TONE_OFS_R1 12'h000
`define APU_TONE_OFS_R2 12'h004
`define APU_TONE_OFS_R3 12'h008
`define APU_TONE_OFS_R4 12'h00C

// timer bit positions
`define APU_TIME_TAP 8
`define APU_NS_TAP0  8
`define APU_NS_TAP1  7
`define APU_NS_TAP2  5
`define APU_NS_TAP3  4

`endif

/* hdl/apu_pkg.sv */
// shared vector types and interrupt source ids of the sound block
`default_nettype none
`include "apu_consts.svh"

package apu_pkg;

  typedef logic [`APU_DATA_W-1:0] data_t;  // register value or sample
  typedef logic [`APU_ADDR_W-1:0] addr_t;
  typedef logic [`APU_TC_W-1:0]   tc_t;    // free-running timer
  typedef logic [`APU_VEC_W-1:0]  vec_t;

  // two's complement dac word, sign on top
  typedef logic [`APU_DATA_W:0] pcm_t;

  // which range N lies in
  //   0  below 0x08, no tone interrupt
  //   1  0x08..0x0f
  //   2  0x10..0x1f
  //   3  0x20..0x3f
  //   4  0x40 and up
  typedef logic [2:0] tone_range_t;

  // lowest value wins priority
  typedef enum logic [1:0] {
    II_TONE = 2'd0,
    II_NS   = 2'd1,
    II_TIME = 2'd2
  } int_id_e;

  typedef logic [2:0] int_vec_t;  // one bit per int_id_e

endpackage

`default_nettype wire

/* hdl/mode_if.sv */
// decoded mode register fields shared by the counters and the interrupt controller
`timescale 1ns/1ps
`default_nettype none

interface mode_if;

  logic [1:0] ns_rate;  // mode[1:0], noise trigger tap
  logic       nss;      // mode[2], noise enable
  logic       tone_ie;  // mode[3]
  logic       ns_ie;    // mode[4]
  logic       time_ie;  // mode[5]

  // register block drives
  modport src (
    output ns_rate, nss, tone_ie, ns_ie, time_ie
  );

  modport dst (
    input ns_rate, nss, tone_ie, ns_ie, time_ie
  );

endinterface

`default_nettype wire

/* hdl/apu_regs.sv */
// host register file, mode field decode and signed pcm formatting
`timescale 1ns/1ps
`default_nettype none
`include "apu_consts.svh"

module apu_regs (
  input  wire logic           CLK,
  input  wire logic           arst_n,
  input  wire logic           wr_strobe,
  input  wire apu_pkg::addr_t wr_addr,
  input  wire apu_pkg::data_t wr_data,
  mode_if.src                 mode,
  output apu_pkg::data_t      n_reload,
  output apu_pkg::pcm_t       pcm_out
);

  apu_pkg::data_t mode_q;
  apu_pkg::data_t n_q;
  apu_pkg::data_t da_q;     // dac sample
  logic [1:0]     sign_q;   // {ts, ss}

  logic           ss;
  logic           ts;
  logic           inv;
  apu_pkg::data_t v;

  ////////////////////////////////////////////////////////////
  // host writes

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      mode_q <= '0;
      n_q    <= '0;
      da_q   <= '0;
      sign_q <= '0;
    end else if (wr_strobe) begin
      case (wr_addr)
        `APU_REG_MODE: mode_q <= wr_data;
        `APU_REG_N:    n_q    <= wr_data;
        `APU_REG_DA:   da_q   <= wr_data;
        `APU_REG_SIGN: sign_q <= wr_data[1:0];
        default:       ;
      endcase
    end
  end

  assign mode.ns_rate = mode_q[1:0];
  assign mode.nss     = mode_q[2];
  assign mode.tone_ie = mode_q[3];
  assign mode.ns_ie   = mode_q[4];
  assign mode.time_ie = mode_q[5];

  assign n_reload = n_q;

  ////////////////////////////////////////////////////////////
  // pcm output

  assign ss  = sign_q[0];
  assign ts  = sign_q[1];
  assign inv = ss ^ ts;   // sample inversion

  always_comb begin
    v = inv ? ~da_q : da_q;
    // negative half stored as ones complement of the magnitude
    pcm_out = {ss, (ss ? ~v : v)};
  end

endmodule

`default_nettype wire

/* hdl/tone_counter.sv */
// tone reload down-counter, reload counter and tone interrupt trigger
`timescale 1ns/1ps
`default_nettype none
`include "apu_consts.svh"

module tone_counter (
  input  wire logic           CLK,
  input  wire logic           arst_n,
  input  wire logic           cycle_en,
  input  wire apu_pkg::data_t n_reload,
  output logic                tone_trig,
  output apu_pkg::tone_range_t tone_range
);

  apu_pkg::data_t        nc;      // down-counter
  logic [`APU_NUC_W-1:0] nuc;     // counts reloads
  logic                  reload;
  logic                  reload_d;
  logic                  cond;
  logic                  cond_d;

  assign reload = (nc == apu_pkg::data_t'(1));

  ////////////////////////////////////////////////////////////
  // counters

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      nc       <= '0;
      nuc      <= '0;
      reload_d <= 1'b0;
    end else if (cycle_en) begin
      nc       <= reload ? n_reload : nc - 1'b1;  // wraps from 0 after reset
      reload_d <= reload;
      if (reload_d)
        nuc <= nuc + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // range and trigger

  always_comb begin
    if (n_reload < 8'h08)
      tone_range = 3'd0;
    else if (n_reload < 8'h10)
      tone_range = 3'd1;
    else if (n_reload < 8'h20)
      tone_range = 3'd2;
    else if (n_reload < 8'h40)
      tone_range = 3'd3;
    else
      tone_range = 3'd4;
  end

  // slower tones divide further through nuc
  always_comb begin
    case (tone_range)
      3'd1:    cond = nuc[2];
      3'd2:    cond = nuc[1];
      3'd3:    cond = nuc[0];
      3'd4:    cond = reload_d;
      default: cond = 1'b0;
    endcase
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      cond_d    <= 1'b0;
      tone_trig <= 1'b0;
    end else begin
      tone_trig <= 1'b0;  // one CLK only
      if (cycle_en) begin
        cond_d    <= cond;
        tone_trig <= cond_d & ~cond;  // falling edge
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/noise_timer.sv */
// free-running timer, time and noise trigger edges, noise lfsr
`timescale 1ns/1ps
`default_nettype none
`include "apu_consts.svh"

module noise_timer (
  input  wire logic CLK,
  input  wire logic arst_n,
  input  wire logic cycle_en,
  mode_if.dst       mode,
  output logic      time_trig,
  output logic      ns_trig,
  output logic      noise_bit
);

  apu_pkg::tc_t           tc;
  logic                   time_d;   // tc msb, last tick
  logic                   tap;
  logic                   tap_d;
  logic                   ns_edge;
  logic [`APU_PNC2_W-1:0] pnc2;

  // noise rate select
  always_comb begin
    case (mode.ns_rate)
      2'd0:    tap = tc[`APU_NS_TAP0];
      2'd1:    tap = tc[`APU_NS_TAP1];
      2'd2:    tap = tc[`APU_NS_TAP2];
      default: tap = tc[`APU_NS_TAP3];
    endcase
  end

  assign ns_edge = tap_d & ~tap;

  ////////////////////////////////////////////////////////////
  // timer and trigger edges

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      tc        <= '0;
      time_d    <= 1'b0;
      tap_d     <= 1'b0;
      time_trig <= 1'b0;
      ns_trig   <= 1'b0;
    end else begin
      time_trig <= 1'b0;
      ns_trig   <= 1'b0;
      if (cycle_en) begin
        tc        <= tc + 1'b1;
        time_d    <= tc[`APU_TIME_TAP];
        tap_d     <= tap;
        time_trig <= time_d & ~tc[`APU_TIME_TAP];  // every 512 ticks
        ns_trig   <= ns_edge;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // lfsr, stepped by the noise edge

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      pnc2 <= '0;
    end else if (cycle_en && ns_edge) begin
      if (mode.nss)
        pnc2 <= {pnc2[1:0], ~(pnc2[1] ^ noise_bit)};
      else
        pnc2 <= {pnc2[1:0], ~pnc2[0]};  // plain toggle chain
    end
  end

  // clearing nss silences at once
  assign noise_bit = mode.nss & pnc2[2];

endmodule

`default_nettype wire

/* hdl/int_ctrl.sv */
// interrupt pending and active state, priority, vector and acknowledge
`timescale 1ns/1ps
`default_nettype none
`include "apu_consts.svh"

module int_ctrl (
  input  wire logic                 CLK,
  input  wire logic                 arst_n,
  input  wire logic                 cycle_en,
  mode_if.dst                       mode,
  input  wire logic                 tone_trig,
  input  wire apu_pkg::tone_range_t tone_range,
  input  wire logic                 ns_trig,
  input  wire logic                 time_trig,
  input  wire logic                 ack_strobe,
  input  wire apu_pkg::int_id_e     ack_id,
  output logic                      int_strobe,
  output apu_pkg::vec_t             int_vec,
  output logic                      int_busy
);

  apu_pkg::int_vec_t    set_pend;
  apu_pkg::int_vec_t    pending;
  apu_pkg::int_vec_t    pend_next;
  apu_pkg::int_vec_t    active;
  apu_pkg::int_vec_t    grant;
  apu_pkg::int_vec_t    ack_mask;
  apu_pkg::tone_range_t rng_q;      // range seen at the tone trigger
  apu_pkg::vec_t        tone_ofs;
  apu_pkg::vec_t        vec_next;
  logic                 do_grant;

  assign set_pend[apu_pkg::II_TONE] = tone_trig & mode.tone_ie;
  assign set_pend[apu_pkg::II_NS]   = ns_trig & mode.ns_ie;
  assign set_pend[apu_pkg::II_TIME] = time_trig & mode.time_ie;

  ////////////////////////////////////////////////////////////
  // priority pick, only while nothing is active

  always_comb begin
    grant = '0;
    if (active == '0) begin
      if (pending[apu_pkg::II_TONE])
        grant[apu_pkg::II_TONE] = 1'b1;
      else if (pending[apu_pkg::II_NS])
        grant[apu_pkg::II_NS] = 1'b1;
      else if (pending[apu_pkg::II_TIME])
        grant[apu_pkg::II_TIME] = 1'b1;
    end
  end

  assign do_grant = cycle_en & (|grant);
  assign ack_mask = ack_strobe ? apu_pkg::int_vec_t'(1) << ack_id : '0;

  // an active source ignores its own trigger
  assign pend_next = (pending | (set_pend & ~active)) & ~(do_grant ? grant : '0);

  always_comb begin
    case (rng_q)
      3'd2:    tone_ofs = `APU_TONE_OFS_R2;
      3'd3:    tone_ofs = `APU_TONE_OFS_R3;
      3'd4:    tone_ofs = `APU_TONE_OFS_R4;
      default: tone_ofs = `APU_TONE_OFS_R1;
    endcase
  end

  always_comb begin
    vec_next = '0;
    if (grant[apu_pkg::II_TONE])
      vec_next = `APU_VEC_TONE + tone_ofs;
    else if (grant[apu_pkg::II_NS])
      vec_next = `APU_VEC_NS;
    else if (grant[apu_pkg::II_TIME])
      vec_next = `APU_VEC_TIME;
  end

  ////////////////////////////////////////////////////////////
  // state

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      pending    <= '0;
      active     <= '0;
      rng_q      <= '0;
      int_strobe <= 1'b0;
      int_vec    <= '0;
    end else begin
      pending    <= pend_next;
      active     <= (active & ~ack_mask) | (do_grant ? grant : '0);  // stray acks drop out
      int_strobe <= do_grant;
      if (set_pend[apu_pkg::II_TONE] && !active[apu_pkg::II_TONE])
        rng_q <= tone_range;
      if (do_grant)
        int_vec <= vec_next;  // held until the next strobe
    end
  end

  assign int_busy = |active;

endmodule

`default_nettype wire

/* hdl/upd1771c_apu.sv */
// top level of the sound block, register file, counters and interrupt controller
`timescale 1ns/1ps
`default_nettype none

module upd1771c_apu (
  input  wire logic             CLK,
  input  wire logic             arst_n,
  input  wire logic             cycle_en,    // one machine cycle per pulse
  input  wire logic             wr_strobe,
  input  wire apu_pkg::addr_t   wr_addr,
  input  wire apu_pkg::data_t   wr_data,
  input  wire logic             ack_strobe,  // reti
  input  wire apu_pkg::int_id_e ack_id,
  output logic                  int_strobe,
  output apu_pkg::vec_t         int_vec,
  output logic                  int_busy,
  output logic                  noise_bit,
  output apu_pkg::pcm_t         pcm_out
);

  apu_pkg::data_t       n_reload;
  apu_pkg::tone_range_t tone_range;
  logic                 tone_trig;
  logic                 ns_trig;
  logic                 time_trig;

  mode_if mode_bus ();

  apu_regs u_regs (
    .CLK       (CLK),
    .arst_n    (arst_n),
    .wr_strobe (wr_strobe),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .mode      (mode_bus.src),
    .n_reload  (n_reload),
    .pcm_out   (pcm_out)
  );

  tone_counter u_tone (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .cycle_en   (cycle_en),
    .n_reload   (n_reload),
    .tone_trig  (tone_trig),
    .tone_range (tone_range)
  );

  noise_timer u_noise (
    .CLK       (CLK),
    .arst_n    (arst_n),
    .cycle_en  (cycle_en),
    .mode      (mode_bus.dst),
    .time_trig (time_trig),
    .ns_trig   (ns_trig),
    .noise_bit (noise_bit)
  );

  int_ctrl u_int (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .cycle_en   (cycle_en),
    .mode       (mode_bus.dst),
    .tone_trig  (tone_trig),
    .tone_range (tone_range),
    .ns_trig    (ns_trig),
    .time_trig  (time_trig),
    .ack_strobe (ack_strobe),
    .ack_id     (ack_id),
    .int_strobe (int_strobe),
    .int_vec    (int_vec),
    .int_busy   (int_busy)
  );

endmodule

`default_nettype wire

/* test/apu_model.svh */
// reference model of the sound block registers, counters, lfsr, interrupts and pcm
`ifndef APU_MODEL_SVH
`define APU_MODEL_SVH

logic [7:0]  m_mode;
logic [7:0]  m_n;
logic [7:0]  m_da;
logic [1:0]  m_sign;       // {ts, ss}
logic [7:0]  m_nc;
logic [2:0]  m_nuc;
logic        m_rl_d;
logic        m_cond_d;
logic        m_tone_trig;
logic [8:0]  m_tc;
logic        m_msb_d;
logic        m_tap_d;
logic        m_time_trig;
logic        m_ns_trig;
logic        m_ns_step;    // lfsr moved on the last edge
logic [2:0]  m_pnc2;
logic [2:0]  m_pend;
logic [2:0]  m_act;
logic [2:0]  m_rng;        // range latched with the tone request
logic        m_strobe;
logic [11:0] m_vec;
int          m_ticks;

function automatic logic [2:0] range_of(input logic [7:0] n);
  if (n[7:6] != 2'b00)
    return 3'd4;
  if (n[5])
    return 3'd3;
  if (n[4])
    return 3'd2;
  if (n[3])
    return 3'd1;
  return 3'd0;
endfunction

function automatic logic [11:0] vec_of(input int id, input logic [2:0] rng);
  if (id == 1)
    return 12'h048;
  if (id == 2)
    return 12'h080;
  return 12'h020 + ((rng < 3'd2) ? 0 : 4 * (rng - 1));  // tone base plus range offset
endfunction

function automatic apu_pkg::int_id_e id_of_vec(input logic [11:0] vec);
  if (vec == 12'h048)
    return apu_pkg::II_NS;
  if (vec == 12'h080)
    return apu_pkg::II_TIME;
  return apu_pkg::II_TONE;
endfunction

function automatic int lowest(input logic [2:0] p);
  for (int i = 0; i < 3; i++)
    if (p[i])
      return i;
  return 3;  // nothing pending
endfunction

function automatic int tap_pos(input logic [1:0] rate);
  case (rate)
    2'd0:    return 8;
    2'd1:    return 7;
    2'd2:    return 5;
    default: return 4;
  endcase
endfunction

function automatic logic [8:0] pcm_expected(input logic [7:0] da, input logic [1:0] sign);
  // ss inverts twice, so the magnitude follows ts alone
  return {sign[0], (sign[1] ? ~da : da)};
endfunction

task automatic model_reset();
  {m_mode, m_n, m_da, m_sign, m_nc, m_nuc} = '0;
  {m_rl_d, m_cond_d, m_tone_trig, m_tc, m_msb_d, m_tap_d} = '0;
  {m_time_trig, m_ns_trig, m_ns_step, m_pnc2} = '0;
  {m_pend, m_act, m_rng, m_strobe, m_vec} = '0;
  m_ticks = 0;
endtask

// one clock edge; every part reads the state from before the edge
task automatic model_step(input logic ce, input logic wr, input logic [1:0] addr,
                          input logic [7:0] data, input logic ack, input logic [1:0] aid);
  logic [2:0] rng;
  logic [2:0] req;
  logic [2:0] grant;
  logic       cond;
  logic       tap;
  logic       reload;
  logic       nb;
  int         win;

  ////////////////////////////////////////////////////////////
  // interrupts
  rng   = range_of(m_n);
  req   = {m_time_trig & m_mode[5], m_ns_trig & m_mode[4], m_tone_trig & m_mode[3]};
  win   = lowest(m_pend);
  grant = (ce && m_act == 3'b000 && win < 3) ? (3'b001 << win) : 3'b000;
  m_strobe = (grant != 3'b000);
  if (m_strobe)
    m_vec = vec_of(win, m_rng);
  if (req[0] && !m_act[0])
    m_rng = rng;
  m_pend = (m_pend | (req & ~m_act)) & ~grant;
  if (ack && aid < 2'd3)
    m_act[aid] = 1'b0;
  m_act = m_act | grant;

  ////////////////////////////////////////////////////////////
  // tone divider
  reload = (m_nc == 8'd1);
  cond   = (rng == 3'd0) ? 1'b0 : (rng == 3'd4) ? m_rl_d : m_nuc[3 - rng];
  m_tone_trig = ce & m_cond_d & ~cond;
  if (ce) begin
    m_cond_d = cond;
    if (m_rl_d)
      m_nuc = m_nuc + 3'd1;
    m_rl_d = reload;
    m_nc   = reload ? m_n : m_nc - 8'd1;
  end

  ////////////////////////////////////////////////////////////
  // timer and noise
  tap         = m_tc[tap_pos(m_mode[1:0])];
  m_ns_step   = ce & m_tap_d & ~tap;
  m_ns_trig   = m_ns_step;
  m_time_trig = ce & m_msb_d & ~m_tc[8];
  if (m_ns_step) begin
    nb     = m_mode[2] & m_pnc2[2];
    m_pnc2 = {m_pnc2[1:0], (m_mode[2] ? ~(m_pnc2[1] ^ nb) : ~m_pnc2[0])};
  end
  if (ce) begin
    m_msb_d = m_tc[8];
    m_tap_d = tap;
    m_tc    = m_tc + 9'd1;
    m_ticks++;
  end

  if (wr) begin
    case (addr)
      2'd0:    m_mode = data;
      2'd1:    m_n    = data;
      2'd2:    m_da   = data;
      default: m_sign = data[1:0];
    endcase
  end
endtask

`endif

/* test/tb_upd1771c_apu.sv */
// testbench of the sound block with clock, reset, random stimulus, model checks, watchdog
`timescale 1ns/1ps
`default_nettype none
`include "apu_consts.svh"

module tb_upd1771c_apu;

  localparam int CLK_PERIOD  = 4;
  localparam int SEED        = 32'h5676;
  localparam int TOTAL_TICKS = 400 + 5000 + 10500 + 5000 + 9000;  // per-test budgets
  localparam int LIMIT_NS    = TOTAL_TICKS * 6 * CLK_PERIOD;

  logic             CLK;
  logic             arst_n;
  logic             cycle_en;
  logic             wr_strobe;
  apu_pkg::addr_t   wr_addr;
  apu_pkg::data_t   wr_data;
  logic             ack_strobe;
  apu_pkg::int_id_e ack_id;
  logic             int_strobe;
  apu_pkg::vec_t    int_vec;
  logic             int_busy;
  logic             noise_bit;
  apu_pkg::pcm_t    pcm_out;

  int          errors;
  int          tests_run;
  int          tests_failed;
  logic        model_live;
  logic [2:0]  pend_prev;   // model pending before the last edge

  `include "apu_model.svh"

  upd1771c_apu dut (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .cycle_en   (cycle_en),
    .wr_strobe  (wr_strobe),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .ack_strobe (ack_strobe),
    .ack_id     (ack_id),
    .int_strobe (int_strobe),
    .int_vec    (int_vec),
    .int_busy   (int_busy),
    .noise_bit  (noise_bit),
    .pcm_out    (pcm_out)
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  always @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      model_reset();
      model_live = 1'b0;
    end else begin
      model_step(cycle_en, wr_strobe, wr_addr, wr_data, ack_strobe, ack_id);
      model_live = 1'b1;
    end
  end

  task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
    assert (got === exp) else begin
      $display("Mismatch at %0t: %s got 'h%0h expected 'h%0h", $time, name, got, exp);
      errors++;
    end
  endtask

  // outputs all come from registers, so the falling edge sees them settled
  always @(negedge CLK) begin
    if (model_live) begin
      check_val("int_strobe", int_strobe, m_strobe);
      check_val("int_busy", int_busy, m_act != 3'b000);
      check_val("int_vec", int_vec, m_vec);
      check_val("noise_bit", noise_bit, m_mode[2] & m_pnc2[2]);
      check_val("pcm_out", pcm_out, pcm_expected(m_da, m_sign));
      if (int_strobe)
        check_val("int_vec source", id_of_vec(int_vec), lowest(pend_prev));  // priority
    end
    pend_prev = m_pend;
  end

  ////////////////////////////////////////////////////////////
  // stimulus

  task automatic step_clk(input logic wr, input logic [1:0] addr, input logic [7:0] data,
                          input logic ack, input apu_pkg::int_id_e aid);
    @(negedge CLK);
    cycle_en   = ($urandom % 3) == 0;  // about one tick in three
    wr_strobe  = wr;
    wr_addr    = addr;
    wr_data    = data;
    ack_strobe = ack;
    ack_id     = aid;
  endtask

  task automatic idle();
    step_clk(1'b0, 2'd0, 8'd0, 1'b0, apu_pkg::II_TONE);
  endtask

  task automatic write_reg(input logic [1:0] addr, input logic [7:0] data);
    step_clk(1'b1, addr, data, 1'b0, apu_pkg::II_TONE);
  endtask

  task automatic ack_int(input apu_pkg::int_id_e id);
    step_clk(1'b0, 2'd0, 8'd0, 1'b1, id);
  endtask

  task automatic run_ticks(input int n);
    int target;
    target = m_ticks + n;
    while (m_ticks < target)
      idle();
  endtask

  task automatic wait_strobe(input int max_ticks, output bit got);
    int limit;
    limit = m_ticks + max_ticks;
    got   = 1'b0;
    while (!got && m_ticks < limit) begin
      idle();
      got = int_strobe;
    end
    assert (got) else begin
      $display("no interrupt strobe within %0d ticks at %0t", max_ticks, $time);
      errors++;
    end
  endtask

  task automatic quiet_ticks(input int n);
    int target;
    target = m_ticks + n;
    while (m_ticks < target) begin
      idle();
      assert (!int_strobe) else begin
        $display("unexpected interrupt strobe with vector 'h%0h at %0t", int_vec, $time);
        errors++;
      end
    end
  endtask

  task automatic report_test(input string name, input int err_start);
    tests_run++;
    if (errors == err_start) begin
      $display("test %0d %s passed", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s failed with %0d errors", tests_run, name, errors - err_start);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // tests

  task automatic pcm_test();
    logic [7:0] da;
    logic [1:0] sg;
    int         e0;
    e0 = errors;
    for (int i = 0; i < 200; i++) begin
      da = $urandom;
      sg = $urandom;
      write_reg(`APU_REG_DA, da);
      write_reg(`APU_REG_SIGN, {6'd0, sg});
      idle();
      check_val("pcm_out", pcm_out, pcm_expected(da, sg));
    end
    report_test("pcm formatting", e0);
  endtask

  task automatic time_test();
    int e0;
    int last;
    bit got;
    e0 = errors;
    write_reg(`APU_REG_MODE, 8'h20);  // time_ie only
    for (int i = 0; i < 5; i++) begin
      wait_strobe(700, got);
      if (!got)
        break;
      check_val("int_vec", int_vec, 12'h080);
      // latency to the strobe is one or two ticks
      assert (i == 0 || (m_ticks - last >= 511 && m_ticks - last <= 513)) else begin
        $display("Mismatch at %0t: time strobe gap got %0d expected 512", $time, m_ticks - last);
        errors++;
      end
      last = m_ticks;
      if (i == 4)
        write_reg(`APU_REG_MODE, 8'h00);
      ack_int(apu_pkg::II_TIME);
    end
    quiet_ticks(2000);
    report_test("time interrupt and enables", e0);
  endtask

  task automatic tone_test();
    logic [7:0] n;
    int         e0;
    bit         got;
    e0 = errors;
    for (int r = 0; r < 5; r++) begin
      if (r == 0)
        n = $urandom % 8;
      else
        n = (8 << (r - 1)) + $urandom % ((r == 4) ? 192 : (8 << (r - 1)));
      write_reg(`APU_REG_MODE, 8'h00);
      write_reg(`APU_REG_N, n);
      run_ticks(300);  // counter settles on the new N
      write_reg(`APU_REG_MODE, 8'h08);
      if (r == 0)
        quiet_ticks(600);
      for (int k = 0; r > 0 && k < 3; k++) begin
        wait_strobe(600, got);
        if (!got)
          break;
        check_val("int_vec", int_vec, 12'h020 + 4 * (r - 1));
        if (k == 2)
          write_reg(`APU_REG_MODE, 8'h00);
        ack_int(apu_pkg::II_TONE);
      end
    end
    report_test("tone vectors", e0);
  endtask

  task automatic priority_test();
    apu_pkg::int_id_e id;
    apu_pkg::int_id_e stray;
    int               e0;
    int               target;
    bit               got;
    e0 = errors;
    write_reg(`APU_REG_N, 8'h40 + $urandom % 64);
    write_reg(`APU_REG_MODE, 8'h3f);
    for (int i = 0; i < 6; i++) begin
      wait_strobe(600, got);
      if (!got)
        break;
      id    = id_of_vec(int_vec);
      stray = apu_pkg::int_id_e'((int'(id) + 1 + $urandom % 2) % 3);
      ack_int(stray);  // other ids are ignored
      target = m_ticks + 200;
      while (m_ticks < target) begin
        idle();
        assert (int_busy && !int_strobe) else begin
          $display("source %0d lost its active state or a second strobe came at %0t",
                   id, $time);
          errors++;
        end
      end
      if (i == 5)
        write_reg(`APU_REG_MODE, 8'h00);
      ack_int(id);
    end
    report_test("priority and single active", e0);
  endtask

  task automatic noise_test();
    int e0;
    int steps;
    int limit;
    e0 = errors;
    for (int r = 0; r < 4; r++) begin
      for (int s = 1; s >= 0; s--) begin
        write_reg(`APU_REG_MODE, {5'd0, s[0], r[1:0]});
        steps = 0;
        limit = m_ticks + 5 * (2 << tap_pos(r[1:0]));
        while (steps < 4 && m_ticks < limit) begin
          idle();
          if (m_ns_step) begin
            steps++;
            check_val("noise_bit", noise_bit, m_mode[2] & m_pnc2[2]);
          end
        end
        assert (steps == 4) else begin
          $display("only %0d noise triggers for rate %0d nss %0d", steps, r, s);
          errors++;
        end
      end
    end
    report_test("noise", e0);
  endtask

  initial begin
    void'($urandom(SEED));
    CLK          = 1'b0;
    arst_n       = 1'b0;
    cycle_en     = 1'b0;
    wr_strobe    = 1'b0;
    wr_addr      = '0;
    wr_data      = '0;
    ack_strobe   = 1'b0;
    ack_id       = apu_pkg::II_TONE;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (3) @(negedge CLK);
    arst_n = 1'b1;
    pcm_test();
    time_test();
    tone_test();
    priority_test();
    noise_test();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

  // hard stop well past the slowest expected run
  initial begin
    #(LIMIT_NS);
    $display("watchdog expired after %0d ticks", m_ticks);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* upd1771c_apu.f */
+incdir+hdl
+incdir+test
hdl/apu_pkg.sv
hdl/mode_if.sv
hdl/apu_regs.sv
hdl/tone_counter.sv
hdl/noise_timer.sv
hdl/int_ctrl.sv
hdl/upd1771c_apu.sv
test/tb_upd1771c_apu.sv

/* Bender.yml */
package:
  name: upd1771c_apu

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/apu_pkg.sv
      - hdl/mode_if.sv
      - hdl/apu_regs.sv
      - hdl/tone_counter.sv
      - hdl/noise_timer.sv
      - hdl/int_ctrl.sv
      - hdl/upd1771c_apu.sv
  - target: test
    include_dirs:
      - hdl
      - test
    files:
      - test/tb_upd1771c_apu.sv
